//--- common/mci_fabric_pkg.sv
// Shared types of the subordinate request fabric
// Bus widths, plain vector typedefs, request and response bundles
// and the privilege flag set driven out of the fabric

package mci_fabric_pkg;

    // Simplex bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int USER_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Byte address
    typedef logic [ADDR_W-1:0] addr_t;
    // Data word
    typedef logic [DATA_W-1:0] data_t;
    // Byte enables, one per data byte
    typedef logic [STRB_W-1:0] strb_t;
    // Requester user tag
    typedef logic [USER_W-1:0] user_t;

    // Request side, held stable while hold is high
    typedef struct packed {
        logic  dv;
        addr_t addr;
        logic  write;
        user_t user;
        data_t wdata;
        strb_t wstrb;
    } cif_req_t;

    // Response side, sampled when dv high and hold low
    typedef struct packed {
        data_t rdata;
        logic  hold;
        logic  error;
    } cif_resp_t;

    // Privilege indications
    typedef struct packed {
        logic mcu_lsu;
        logic mcu_ifu;
        logic mcu;
        logic clp;
        logic soc;
    } priv_t;

endpackage

//--- common/mci_map_pkg.sv
// Address map of the subordinate port
// Region bases and sizes, one-hot target select and router states

package mci_map_pkg;

    // MCU SRAM capacity in KB
    localparam int MCU_SRAM_SIZE_KB = 1024;

    // Control registers
    localparam mci_fabric_pkg::addr_t REG_BASE   = 32'h0000_0000;
    localparam mci_fabric_pkg::addr_t REG_SIZE   = 32'h0000_1000;
    // Mailboxes, 256 KB each
    localparam mci_fabric_pkg::addr_t MBOX0_BASE = 32'h0040_0000;
    localparam mci_fabric_pkg::addr_t MBOX0_SIZE = 32'h0004_0000;
    localparam mci_fabric_pkg::addr_t MBOX1_BASE = 32'h0080_0000;
    localparam mci_fabric_pkg::addr_t MBOX1_SIZE = 32'h0004_0000;
    // MCU SRAM, length follows the KB size
    localparam mci_fabric_pkg::addr_t SRAM_BASE  = 32'h00C0_0000;
    localparam mci_fabric_pkg::addr_t SRAM_SIZE  = MCU_SRAM_SIZE_KB * 1024;

    // Bit positions inside target_sel_t
    localparam int SEL_REG   = 0;
    localparam int SEL_SRAM  = 1;
    localparam int SEL_MBOX0 = 2;
    localparam int SEL_MBOX1 = 3;

    // One-hot target select, zero when unmapped
    typedef logic [3:0] target_sel_t;

    // Router FSM
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        ERR
    } router_state_e;

endpackage

//--- fabric/mci_addr_decode.sv
// Address decoder of the request fabric
// One-hot target select and offset inside the selected region

`timescale 1ns/1ps

module mci_addr_decode (
    input  mci_fabric_pkg::addr_t      addr,
    output mci_map_pkg::target_sel_t   target_sel,
    output mci_fabric_pkg::addr_t      offset
);

    import mci_fabric_pkg::*;
    import mci_map_pkg::*;

    // Distance from each region base
    addr_t reg_off;
    addr_t sram_off;
    addr_t mbox0_off;
    addr_t mbox1_off;

    // Wraps below the base, so one compare covers both bounds
    assign reg_off   = addr - REG_BASE;
    assign sram_off  = addr - SRAM_BASE;
    assign mbox0_off = addr - MBOX0_BASE;
    assign mbox1_off = addr - MBOX1_BASE;

    always_comb begin
        // Unmapped by default
        target_sel = '0;
        offset     = '0;

        // Regions are disjoint, order of checks is arbitrary
        if (reg_off < REG_SIZE) begin
            target_sel[SEL_REG] = 1'b1;
            offset              = reg_off;
        end
        else if (sram_off < SRAM_SIZE) begin
            target_sel[SEL_SRAM] = 1'b1;
            offset               = sram_off;
        end
        else if (mbox0_off < MBOX0_SIZE) begin
            target_sel[SEL_MBOX0] = 1'b1;
            offset                = mbox0_off;
        end
        else if (mbox1_off < MBOX1_SIZE) begin
            target_sel[SEL_MBOX1] = 1'b1;
            offset                = mbox1_off;
        end
    end

endmodule

//--- fabric/mci_priv_classify.sv
// Privilege classifier
// Matches the request user tag against the LSU, IFU and CLP straps

`timescale 1ns/1ps

module mci_priv_classify (
    input  logic                   dv,
    input  mci_fabric_pkg::user_t  user,
    input  mci_fabric_pkg::user_t  strap_mcu_lsu_user,
    input  mci_fabric_pkg::user_t  strap_mcu_ifu_user,
    input  mci_fabric_pkg::user_t  strap_clp_user,
    output mci_fabric_pkg::priv_t  priv
);

    // Raw strap matches
    logic lsu_hit;
    logic ifu_hit;
    logic clp_hit;

    assign lsu_hit = (user == strap_mcu_lsu_user);
    assign ifu_hit = (user == strap_mcu_ifu_user);
    assign clp_hit = (user == strap_clp_user);

    always_comb begin
        // Nothing flagged without a request
        priv = '0;
        if (dv) begin
            priv.mcu_lsu = lsu_hit;
            priv.mcu_ifu = ifu_hit;
            priv.mcu     = lsu_hit | ifu_hit;
            // MCU wins when a strap value is shared with CLP
            priv.clp     = clp_hit & ~(lsu_hit | ifu_hit);
            // Anyone else counts as SoC
            priv.soc     = ~(lsu_hit | ifu_hit | clp_hit);
        end
    end

endmodule

//--- fabric/mci_req_router.sv
// Request router of the subordinate fabric
// Access check, target strobing, response return
// and the IDLE/BUSY/ERR FSM

`timescale 1ns/1ps

module mci_req_router (
    input  logic                       clk,
    input  logic                       reset,
    input  mci_fabric_pkg::cif_req_t   soc_req_in,
    input  mci_map_pkg::target_sel_t   target_sel,
    input  mci_fabric_pkg::addr_t      offset,
    input  mci_fabric_pkg::priv_t      priv,
    output mci_fabric_pkg::cif_resp_t  soc_resp,
    output mci_fabric_pkg::cif_req_t   reg_req,
    output mci_fabric_pkg::cif_req_t   sram_req,
    output mci_fabric_pkg::cif_req_t   mbox0_req,
    output mci_fabric_pkg::cif_req_t   mbox1_req,
    input  mci_fabric_pkg::cif_resp_t  reg_resp,
    input  mci_fabric_pkg::cif_resp_t  sram_resp,
    input  mci_fabric_pkg::cif_resp_t  mbox0_resp,
    input  mci_fabric_pkg::cif_resp_t  mbox1_resp
);

    import mci_fabric_pkg::*;
    import mci_map_pkg::*;

    router_state_e state_q;
    router_state_e state_d;
    // Target latched while it holds
    target_sel_t   sel_q;
    target_sel_t   sel_d;
    // Target strobed in this cycle
    target_sel_t   route_sel;
    logic          denied;
    cif_req_t      fwd_req;
    cif_resp_t     tgt_resp;

    // Unmapped, or SRAM write from a non-MCU non-CLP requester
    assign denied = (target_sel == '0) ||
                    (target_sel[SEL_SRAM] && soc_req_in.write && !(priv.mcu || priv.clp));

    // Request as seen by a target, region offset in place of address
    always_comb begin
        fwd_req      = soc_req_in;
        fwd_req.addr = offset;
    end

    // Which target gets the strobe
    always_comb begin
        route_sel = '0;
        // No target strobed during reset
        if (!reset) begin
            if (state_q == IDLE && soc_req_in.dv && !denied) begin
                route_sel = target_sel;
            end
            else if (state_q == BUSY) begin
                route_sel = sel_q;
            end
        end
    end

    // Only the routed target sees dv
    always_comb begin
        reg_req      = fwd_req;
        sram_req     = fwd_req;
        mbox0_req    = fwd_req;
        mbox1_req    = fwd_req;
        reg_req.dv   = soc_req_in.dv & route_sel[SEL_REG];
        sram_req.dv  = soc_req_in.dv & route_sel[SEL_SRAM];
        mbox0_req.dv = soc_req_in.dv & route_sel[SEL_MBOX0];
        mbox1_req.dv = soc_req_in.dv & route_sel[SEL_MBOX1];
    end

    // Return path mux, route_sel is one-hot or zero
    always_comb begin
        tgt_resp = '0;
        if (route_sel[SEL_REG])   tgt_resp = reg_resp;
        if (route_sel[SEL_SRAM])  tgt_resp = sram_resp;
        if (route_sel[SEL_MBOX0]) tgt_resp = mbox0_resp;
        if (route_sel[SEL_MBOX1]) tgt_resp = mbox1_resp;
    end

    // Response to requester and next state
    always_comb begin
        state_d  = state_q;
        sel_d    = sel_q;
        soc_resp = '0;
        case (state_q)
            IDLE: begin
                if (soc_req_in.dv && denied) begin
                    // Stall one cycle, error follows in ERR
                    soc_resp.hold = 1'b1;
                    state_d       = ERR;
                end
                else if (soc_req_in.dv) begin
                    soc_resp = tgt_resp;
                    if (tgt_resp.hold) begin
                        sel_d   = target_sel;
                        state_d = BUSY;
                    end
                end
            end
            BUSY: begin
                soc_resp = tgt_resp;
                // Leave once the target lets go
                if (!soc_req_in.dv || !tgt_resp.hold) begin
                    state_d = IDLE;
                end
            end
            ERR: begin
                soc_resp.error = 1'b1;
                state_d        = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            sel_q   <= '0;
        end
        else begin
            state_q <= state_d;
            sel_q   <= sel_d;
        end
    end

endmodule

//--- src/mci_sub_fabric_top.sv
// Top level of the subordinate request fabric
// Address decoder and privilege classifier feed the router
// Privilege flags also leave the block

`timescale 1ns/1ps

module mci_sub_fabric_top (
    input  logic                       clk,
    input  logic                       reset,
    // Requester side
    input  mci_fabric_pkg::cif_req_t   soc_req_in,
    output mci_fabric_pkg::cif_resp_t  soc_resp,
    // Control registers
    output mci_fabric_pkg::cif_req_t   reg_req,
    input  mci_fabric_pkg::cif_resp_t  reg_resp,
    // MCU SRAM
    output mci_fabric_pkg::cif_req_t   sram_req,
    input  mci_fabric_pkg::cif_resp_t  sram_resp,
    // Mailboxes
    output mci_fabric_pkg::cif_req_t   mbox0_req,
    input  mci_fabric_pkg::cif_resp_t  mbox0_resp,
    output mci_fabric_pkg::cif_req_t   mbox1_req,
    input  mci_fabric_pkg::cif_resp_t  mbox1_resp,
    // Privileged user straps
    input  mci_fabric_pkg::user_t      strap_mcu_lsu_user,
    input  mci_fabric_pkg::user_t      strap_mcu_ifu_user,
    input  mci_fabric_pkg::user_t      strap_clp_user,
    output mci_fabric_pkg::priv_t      priv
);

    import mci_fabric_pkg::*;
    import mci_map_pkg::*;

    // Decoder results
    target_sel_t target_sel;
    addr_t       offset;

    mci_addr_decode i_mci_addr_decode (
        .addr       (soc_req_in.addr),
        .target_sel (target_sel),
        .offset     (offset)
    );

    // Classification runs beside the decode
    mci_priv_classify i_mci_priv_classify (
        .dv                 (soc_req_in.dv),
        .user               (soc_req_in.user),
        .strap_mcu_lsu_user (strap_mcu_lsu_user),
        .strap_mcu_ifu_user (strap_mcu_ifu_user),
        .strap_clp_user     (strap_clp_user),
        .priv               (priv)
    );

    mci_req_router i_mci_req_router (
        .clk        (clk),
        .reset      (reset),
        .soc_req_in (soc_req_in),
        .target_sel (target_sel),
        .offset     (offset),
        .priv       (priv),
        .soc_resp   (soc_resp),
        .reg_req    (reg_req),
        .sram_req   (sram_req),
        .mbox0_req  (mbox0_req),
        .mbox1_req  (mbox1_req),
        .reg_resp   (reg_resp),
        .sram_resp  (sram_resp),
        .mbox0_resp (mbox0_resp),
        .mbox1_resp (mbox1_resp)
    );

endmodule

//--- testbench/mci_sub_fabric_checker.sv
// Bound assertions on the fabric top-level ports
// Single target strobe, quiet targets in reset, error never with hold

`timescale 1ns/1ps

module mci_sub_fabric_checker (
    input logic                       clk,
    input logic                       reset,
    input mci_fabric_pkg::cif_resp_t  soc_resp,
    input mci_fabric_pkg::cif_req_t   reg_req,
    input mci_fabric_pkg::cif_req_t   sram_req,
    input mci_fabric_pkg::cif_req_t   mbox0_req,
    input mci_fabric_pkg::cif_req_t   mbox1_req
);

    logic [3:0]  tgt_dv;
    // Read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    assign tgt_dv = {mbox1_req.dv, mbox0_req.dv, sram_req.dv, reg_req.dv};

    // At most one target strobed
    assert property (@(posedge clk) disable iff (reset) $onehot0(tgt_dv))
    else begin
        fail_count++;
        $error("more than one target dv high: %b", tgt_dv);
    end

    // Targets stay idle in reset
    assert property (@(posedge clk) reset |-> tgt_dv == '0)
    else begin
        fail_count++;
        $error("target dv high during reset: %b", tgt_dv);
    end

    // Error completion never stalled
    assert property (@(posedge clk) disable iff (reset) !(soc_resp.error && soc_resp.hold))
    else begin
        fail_count++;
        $error("error and hold high together");
    end

endmodule

bind mci_sub_fabric_top mci_sub_fabric_checker i_mci_sub_fabric_checker (
    .clk       (clk),
    .reset     (reset),
    .soc_resp  (soc_resp),
    .reg_req   (reg_req),
    .sram_req  (sram_req),
    .mbox0_req (mbox0_req),
    .mbox1_req (mbox1_req)
);

//--- testbench/tb_mci_sub_fabric.sv
// Testbench of the subordinate request fabric
// Clock and reset, random requests, four target memory models,
// reference address map and privilege rules, per-cycle checks

`timescale 1ns/1ps

module tb_mci_sub_fabric;

    import mci_fabric_pkg::*;
    import mci_map_pkg::*;

    localparam int N_XFER     = 400;
    localparam int WAIT_LIMIT = 50;

    logic      clk;
    logic      reset;
    cif_req_t  soc_req_in;
    cif_resp_t soc_resp;
    // Target ports in select bit order reg, sram, mbox0, mbox1
    cif_req_t  tgt_req [4];
    cif_resp_t tgt_resp [4];
    user_t     strap_lsu;
    user_t     strap_ifu;
    user_t     strap_clp;
    priv_t     priv;
    integer    seed = 32'h9dae_0efe;

    // Target model state, word storage keyed by target and offset
    data_t mem [logic [31:0]];
    int    hold_left [4];
    addr_t err_off [4];
    addr_t base [4];
    addr_t size [4];

    mci_sub_fabric_top i_mci_sub_fabric_top (
        .clk                (clk),
        .reset              (reset),
        .soc_req_in         (soc_req_in),
        .soc_resp           (soc_resp),
        .reg_req            (tgt_req[0]),
        .reg_resp           (tgt_resp[0]),
        .sram_req           (tgt_req[1]),
        .sram_resp          (tgt_resp[1]),
        .mbox0_req          (tgt_req[2]),
        .mbox0_resp         (tgt_resp[2]),
        .mbox1_req          (tgt_req[3]),
        .mbox1_resp         (tgt_resp[3]),
        .strap_mcu_lsu_user (strap_lsu),
        .strap_mcu_ifu_user (strap_ifu),
        .strap_clp_user     (strap_clp),
        .priv               (priv)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] mem_key(int t, addr_t off);
        return {t[1:0], off[31:2]};
    endfunction

    // Unwritten words read back a pattern of the whole offset
    function automatic data_t mem_read(int t, addr_t off);
        if (mem.exists(mem_key(t, off))) begin
            return mem[mem_key(t, off)];
        end
        return {off[15:0], off[31:16]} ^ (32'h5a3c_0f96 + t);
    endfunction

    function automatic data_t merge_bytes(data_t old, data_t wd, strb_t st);
        data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) begin
                r[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return r;
    endfunction

    // Target models, hold first, error only on the completing cycle
    always_comb begin
        for (int t = 0; t < 4; t++) begin
            tgt_resp[t].hold  = tgt_req[t].dv && (hold_left[t] != 0);
            tgt_resp[t].error = tgt_req[t].dv && (hold_left[t] == 0)
                                && (tgt_req[t].addr == err_off[t]);
            tgt_resp[t].rdata = tgt_req[t].dv ? mem_read(t, tgt_req[t].addr) : '0;
        end
    end

    always @(posedge clk) begin
        for (int t = 0; t < 4; t++) begin
            if (tgt_req[t].dv && !tgt_resp[t].hold && tgt_req[t].write
                && !tgt_resp[t].error) begin
                mem[mem_key(t, tgt_req[t].addr)] = merge_bytes(
                    mem_read(t, tgt_req[t].addr), tgt_req[t].wdata, tgt_req[t].wstrb);
            end
            if (tgt_req[t].dv && hold_left[t] > 0) begin
                hold_left[t] <= hold_left[t] - 1;
            end
        end
    end

    // Reference address map, -1 when unmapped
    function automatic int ref_decode(addr_t a, output addr_t off);
        off = '0;
        for (int t = 0; t < 4; t++) begin
            if (a >= base[t] && a < base[t] + size[t]) begin
                off = a - base[t];
                return t;
            end
        end
        return -1;
    endfunction

    // Reference privilege rule for a valid request, MCU over CLP on shared straps
    function automatic priv_t ref_priv(user_t u);
        priv_t p;
        p.mcu_lsu = (u == strap_lsu);
        p.mcu_ifu = (u == strap_ifu);
        p.mcu     = p.mcu_lsu | p.mcu_ifu;
        p.clp     = (u == strap_clp) && !p.mcu;
        p.soc     = !p.mcu && !p.clp;
        return p;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string msg);
        abort_run($sformatf("[FAIL] %0t %s", $time, msg));
    endtask

    // Nothing strobed, nothing flagged, no response
    task automatic check_quiet();
        assert (priv == '0)
        else report_mismatch($sformatf("priv %b while dv low", priv));
        assert (!soc_resp.hold && !soc_resp.error)
        else report_mismatch($sformatf("resp hold %b error %b while idle",
                                       soc_resp.hold, soc_resp.error));
        for (int t = 0; t < 4; t++) begin
            assert (!tgt_req[t].dv)
            else report_mismatch($sformatf("target %0d dv high while idle", t));
        end
    endtask

    task automatic check_cycle(int tgt, logic denied, addr_t off, priv_t exp_priv);
        logic exp_dv;
        assert (priv == exp_priv)
        else report_mismatch($sformatf("priv %b, expected %b", priv, exp_priv));
        for (int t = 0; t < 4; t++) begin
            exp_dv = !denied && (t == tgt);
            assert (tgt_req[t].dv == exp_dv)
            else report_mismatch($sformatf("target %0d dv %b, expected %b",
                                           t, tgt_req[t].dv, exp_dv));
            if (exp_dv) begin
                assert (tgt_req[t].addr == off && tgt_req[t].write == soc_req_in.write
                        && tgt_req[t].user == soc_req_in.user
                        && tgt_req[t].wdata == soc_req_in.wdata
                        && tgt_req[t].wstrb == soc_req_in.wstrb)
                else report_mismatch($sformatf("target %0d request differs, addr %h exp %h",
                                               t, tgt_req[t].addr, off));
            end
        end
    endtask

    task automatic run_xfer();
        int    r;
        int    tgt;
        int    cycles;
        int    exp_cycles;
        int    hold_n [4];
        addr_t off;
        logic  denied;
        logic  exp_err;
        data_t old_word;
        data_t new_word;
        priv_t exp_priv;

        // About 80% inside a region, the rest at or above 0x0100_0000
        r = {$random(seed)} % 5;
        if (r < 4) begin
            off = ({$random(seed)} % 16) * 4;
            if ($random(seed) & 1) begin
                off = off + size[r] - 64;
            end
            soc_req_in.addr = base[r] + off;
        end
        else begin
            soc_req_in.addr = ($random(seed) | 32'h0100_0000) & 32'hffff_fffc;
        end
        case ({$random(seed)} % 4)
            0: soc_req_in.user = strap_lsu;
            1: soc_req_in.user = strap_ifu;
            2: soc_req_in.user = strap_clp;
            default: soc_req_in.user = $random(seed);
        endcase
        r = $random(seed);
        soc_req_in.write = r[0];
        soc_req_in.wstrb = r[4:1];
        soc_req_in.wdata = $random(seed);
        // Hold counts take effect with the request
        for (int t = 0; t < 4; t++) begin
            hold_n[t]    = {$random(seed)} % 4;
            hold_left[t] <= hold_n[t];
        end
        soc_req_in.dv = 1'b1;

        tgt      = ref_decode(soc_req_in.addr, off);
        exp_priv = ref_priv(soc_req_in.user);
        denied   = (tgt < 0) || (tgt == 1 && soc_req_in.write
                                 && !exp_priv.mcu && !exp_priv.clp);
        old_word = '0;
        if (denied) begin
            exp_err    = 1'b1;
            exp_cycles = 1;
        end
        else begin
            exp_err    = (off == err_off[tgt]);
            exp_cycles = hold_n[tgt];
        end
        if (tgt >= 0) begin
            old_word = mem_read(tgt, off);
        end

        cycles = 0;
        @(negedge clk);
        check_cycle(tgt, denied, off, exp_priv);
        while (soc_resp.hold) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("Transfer did not complete within 50 cycles");
            end
            @(negedge clk);
            check_cycle(tgt, denied, off, exp_priv);
        end

        assert (cycles == exp_cycles)
        else report_mismatch($sformatf("completion after %0d cycles, expected %0d",
                                       cycles, exp_cycles));
        assert (soc_resp.error == exp_err)
        else report_mismatch($sformatf("error %b, expected %b at addr %h",
                                       soc_resp.error, exp_err, soc_req_in.addr));
        if (!soc_req_in.write && !exp_err) begin
            assert (soc_resp.rdata == old_word)
            else report_mismatch($sformatf("rdata %h, expected %h", soc_resp.rdata, old_word));
        end

        @(posedge clk);
        #5;
        soc_req_in.dv = 1'b0;
        // Memory after the completing edge
        if (tgt >= 0) begin
            new_word = old_word;
            if (soc_req_in.write && !exp_err) begin
                new_word = merge_bytes(old_word, soc_req_in.wdata, soc_req_in.wstrb);
            end
            assert (mem_read(tgt, off) == new_word)
            else report_mismatch($sformatf("target %0d word %h, expected %h",
                                           tgt, mem_read(tgt, off), new_word));
        end
        // Occasional gap between requests
        if ($random(seed) & 1) begin
            @(negedge clk);
            check_quiet();
            @(posedge clk);
            #5;
        end
    endtask

    initial begin
        reset      = 1'b1;
        soc_req_in = '0;
        strap_lsu  = $random(seed);
        strap_ifu  = $random(seed);
        strap_clp  = $random(seed);
        base       = '{REG_BASE, SRAM_BASE, MBOX0_BASE, MBOX1_BASE};
        size       = '{REG_SIZE, SRAM_SIZE, MBOX0_SIZE, MBOX1_SIZE};
        for (int t = 0; t < 4; t++) begin
            hold_left[t] <= 0;
            err_off[t]   = 32'h8 + 4 * t;
        end

        // Legal SRAM write from CLP held during the first half of reset
        soc_req_in.dv    = 1'b1;
        soc_req_in.addr  = SRAM_BASE;
        soc_req_in.write = 1'b1;
        soc_req_in.user  = strap_clp;
        repeat (5) @(posedge clk);
        #5;
        // Unmapped request for the rest of reset
        soc_req_in.addr = 32'hffff_0000;
        repeat (5) @(posedge clk);
        #5;
        soc_req_in = '0;
        reset      = 1'b0;
        @(negedge clk);
        check_quiet();
        @(posedge clk);
        #5;

        for (int i = 0; i < N_XFER; i++) begin
            // Second half shares the LSU value with CLP
            if (i == N_XFER / 2) begin
                strap_clp = strap_lsu;
            end
            run_xfer();
        end

        if (i_mci_sub_fabric_top.i_mci_sub_fabric_checker.fail_count != 0) begin
            abort_run("Bound assertions on the top-level ports failed");
        end
        else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- tb.f
common/mci_fabric_pkg.sv
common/mci_map_pkg.sv
fabric/mci_addr_decode.sv
fabric/mci_priv_classify.sv
fabric/mci_req_router.sv
src/mci_sub_fabric_top.sv
testbench/mci_sub_fabric_checker.sv
testbench/tb_mci_sub_fabric.sv

//--- Bender.yml
package:
  name: mci_sub_fabric

sources:
  # Packages first, the map package uses the fabric types
  - common/mci_fabric_pkg.sv
  - common/mci_map_pkg.sv
  # Fabric blocks and top level
  - fabric/mci_addr_decode.sv
  - fabric/mci_priv_classify.sv
  - fabric/mci_req_router.sv
  - src/mci_sub_fabric_top.sv
  # Testbench and bound checker
  - target: test
    files:
      - testbench/mci_sub_fabric_checker.sv
      - testbench/tb_mci_sub_fabric.sv
